/* compile.f */
+incdir+hdl
hdl/icache_pkg.sv
hdl/icache_tag_array.sv
hdl/icache_data_array.sv
hdl/icache_plru.sv
hdl/icache_ctrl.sv
hdl/icache_top.sv
sim/icache_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module icache_tb \
    -f compile.f \
    --Mdir obj_dir \
    -o icache_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/icache_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "Simulation exited with an error"
    exit 1
fi

cat sim.log
if grep -q "Finished with no errors" sim.log; then
    exit 0
fi
exit 1

/* sim/icache_tb.sv */
`timescale 1ns/10ps

module icache_tb;
    import icache_pkg::*;

    // Sweep, reset and a generous per-transaction budget
    localparam int N_FETCH     = 660;
    localparam int N_OP        = 153;
    localparam int CYCLE_LIMIT = 128 + 8 + 64 * (N_FETCH + N_OP);

    logic        clk;
    logic        rstn;
    logic        inst_req;
    logic [31:0] inst_addr;
    logic        inst_addr_ok;
    logic        inst_data_ok;
    word_t       inst_rdata;
    logic        cache_req;
    cache_op_e   cache_op;
    logic [31:0] cache_addr;
    logic        cache_op_ok;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    word_t       rdata;
    logic        rvalid;
    logic        rlast;
    logic        rready;

    icache_top dut_i (.*);

    logic [31:0] rng = 32'he13f_4214;
    int          cycle_cnt = 0;
    int          err_cnt = 0;
    int          test_err = 0;
    int          test_cnt = 0;
    int          fail_cnt = 0;
    string       test_name = "";
    logic        rst_release = 1'b0;
    logic        acc;
    int          n_ret;
    int          op_ok_cnt;
    logic [31:0] burst_base;
    int          burst_left = 0;
    int          burst_idx = 0;
    logic [31:0] exp_word_q [$];
    logic [31:0] exp_burst_q [$];

    // Reference model of tags, valid bits and tree bits
    logic [19:0] m_tag   [4][128];
    logic        m_valid [4][128];
    logic [2:0]  m_plru  [128];

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Watchdog
    initial begin
        while (cycle_cnt <= CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not complete within %0d cycles", CYCLE_LIMIT);
        $display("Finished with errors");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // Memory contents as a function of the word address
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        logic [31:0] word_addr;
        word_addr = {a[31:2], 2'b00};
        return (word_addr * 32'h9e37_79b9) ^ 32'h5bd1_e995
               ^ {word_addr[15:0], word_addr[31:16]};
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s %s expected %h actual %h", test_name, name, exp, act);
            err_cnt++;
            test_err++;
        end
    endtask

    task automatic fail_note(input string msg);
        $display("[ERROR] %s: %s", test_name, msg);
        err_cnt++;
        test_err++;
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    function automatic int model_find(input logic [31:0] a);
        for (int w = 0; w < 4; w++) begin
            if (m_valid[w][a[11:5]] && m_tag[w][a[11:5]] == a[31:12]) begin
                return w;
            end
        end
        return -1;
    endfunction

    function automatic int model_victim(input logic [6:0] idx);
        logic [2:0] b;
        b = m_plru[idx];
        if (!b[2]) begin
            return b[1] ? 1 : 0;
        end
        return b[0] ? 3 : 2;
    endfunction

    task automatic model_touch(input logic [6:0] idx, input int w);
        case (w)
            0: m_plru[idx][2:1] = 2'b11;
            1: m_plru[idx][2:1] = 2'b10;
            2: {m_plru[idx][2], m_plru[idx][0]} = 2'b01;
            default: {m_plru[idx][2], m_plru[idx][0]} = 2'b00;
        endcase
    endtask

    task automatic model_access(input logic [31:0] a);
        int w;
        w = model_find(a);
        if (w < 0) begin
            w = model_victim(a[11:5]);
            m_tag[w][a[11:5]] = a[31:12];
            m_valid[w][a[11:5]] = 1'b1;
            exp_burst_q.push_back({a[31:2], 2'b00});
        end
        model_touch(a[11:5], w);
        exp_word_q.push_back(mem_word(a));
    endtask

    task automatic model_op(input cache_op_e op, input logic [31:0] a);
        int w;
        if (op == OP_INDEX_INVALID) begin
            m_valid[a[13:12]][a[11:5]] = 1'b0;
        end else begin
            w = model_find(a);
            if (w >= 0) begin
                m_valid[w][a[11:5]] = 1'b0;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Cycle driver, memory responder and monitor
    ////////////////////////////////////////////////////////////
    task automatic cycle_begin();
        logic [31:0] r;
        logic [31:0] wa;
        @(negedge clk);
        if (rst_release) begin
            rstn = 1'b1;
            rst_release = 1'b0;
        end
        r = next_rand();
        arready = (r[1:0] == 2'b00);
        if (burst_left > 0) begin
            wa = {burst_base[31:5], 3'(burst_base[4:2] + 3'(burst_idx)), 2'b00};
            rvalid = (r[3:2] != 2'b00);
            rdata  = mem_word(wa);
            rlast  = (burst_left == 1);
        end else begin
            rvalid = 1'b0;
            rdata  = '0;
            rlast  = 1'b0;
        end
    endtask

    // Samples just before the rising edge, when every output is settled
    task automatic cycle_end();
        #4;
        acc = inst_req && inst_addr_ok;
        if (rvalid && rready) begin
            burst_idx++;
            burst_left--;
        end
        if (arvalid && arready) begin
            if (exp_burst_q.size() == 0) begin
                fail_note($sformatf("burst to %h with no miss expected", araddr));
            end else begin
                check("araddr", exp_burst_q.pop_front(), araddr);
            end
            burst_base = araddr;
            burst_left = 8;
            burst_idx  = 0;
        end
        if (inst_data_ok) begin
            if (exp_word_q.size() == 0) begin
                fail_note("data returned with no fetch outstanding");
            end else begin
                check("rdata", exp_word_q.pop_front(), inst_rdata);
            end
            n_ret++;
        end
        if (cache_op_ok) begin
            op_ok_cnt++;
        end
    endtask

    task automatic run_fetches(input logic [31:0] addrs [$], output int wait_cycles);
        int i;
        i = 0;
        n_ret = 0;
        wait_cycles = 0;
        while (n_ret < addrs.size()) begin
            cycle_begin();
            if (i < addrs.size()) begin
                inst_req  = 1'b1;
                inst_addr = addrs[i];
            end else begin
                inst_req = 1'b0;
            end
            cycle_end();
            if (i == 0 && !acc) begin
                wait_cycles++;
            end
            if (acc) begin
                model_access(addrs[i]);
                i++;
            end
        end
        check("missing bursts", 0, exp_burst_q.size());
    endtask

    task automatic run_op(input cache_op_e op, input logic [31:0] a);
        op_ok_cnt = 0;
        cycle_begin();
        cache_req  = 1'b1;
        cache_op   = op;
        cache_addr = a;
        cycle_end();
        while (op_ok_cnt == 0) begin
            cycle_begin();
            cycle_end();
        end
        cycle_begin();
        cache_req = 1'b0;
        cycle_end();
        check("op_ok pulses", 1, op_ok_cnt);
        model_op(op, a);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err  = 0;
    endtask

    task automatic end_test();
        test_cnt++;
        if (test_err != 0) begin
            fail_cnt++;
        end
        $display("test %-14s %s (%0d errors)", test_name, (test_err == 0) ? "ok" : "FAIL",
                 test_err);
    endtask

    function automatic logic [31:0] pool_addr(input logic [31:0] r);
        logic [6:0] idx;
        case (r[4:3])
            2'd0:    idx = 7'h03;
            2'd1:    idx = 7'h40;
            2'd2:    idx = 7'h63;
            default: idx = 7'h2a;
        endcase
        return {20'h5_0000 | {17'h0, r[2:0]}, idx, r[7:5], r[9:8]};
    endfunction

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        logic [31:0] q [$];
        logic [31:0] r;
        logic [31:0] evicted;
        int          w;
        int          wc;

        rstn = 1'b0;
        inst_req = 1'b0;
        inst_addr = '0;
        cache_req = 1'b0;
        cache_op = OP_INDEX_INVALID;
        cache_addr = '0;
        arready = 1'b0;
        rdata = '0;
        rvalid = 1'b0;
        rlast = 1'b0;
        for (int s = 0; s < 128; s++) begin
            m_plru[s] = '0;
            for (int k = 0; k < 4; k++) begin
                m_valid[k][s] = 1'b0;
                m_tag[k][s] = '0;
            end
        end

        start_test("reset");
        for (int c = 0; c < 8; c++) begin
            cycle_begin();
            cycle_end();
            check("reset outputs", 0,
                  32'({inst_addr_ok, inst_data_ok, cache_op_ok, arvalid, rready}));
        end
        end_test();

        // First fetch waits out the whole sweep
        start_test("first_fetch");
        rst_release = 1'b1;
        q = {32'h0000_1004, 32'h1234_567a, 32'h8000_0ffc, 32'hdead_beec};
        run_fetches(q, wc);
        check("sweep cycles", 128, wc);
        end_test();

        start_test("resident_mix");
        q = {};
        for (int k = 0; k < 40; k++) begin
            r = next_rand();
            q.push_back({20'h0_0abc + {18'h0, r[1:0]}, 7'h11, r[4:2], 2'b00});
        end
        run_fetches(q, wc);
        end_test();

        start_test("plru_evict");
        q = {};
        for (int k = 0; k < 5; k++) begin
            q.push_back({20'h3_0000 + 20'(k), 7'h2a, 5'h08});
        end
        run_fetches(q, wc);
        evicted = '0;
        q = {};
        for (int k = 0; k < 5; k++) begin
            if (model_find({20'h3_0000 + 20'(k), 7'h2a, 5'h0}) < 0) begin
                evicted = {20'h3_0000 + 20'(k), 7'h2a, 5'h14};
            end else begin
                q.push_back({20'h3_0000 + 20'(k), 7'h2a, 5'h1c});
            end
        end
        q.push_back(evicted);
        run_fetches(q, wc);
        end_test();

        start_test("index_inval");
        w = model_find(evicted);
        run_op(OP_INDEX_INVALID, {18'h0, 2'(w), 7'h2a, 5'h0});
        q = {evicted};
        run_fetches(q, wc);
        end_test();

        start_test("hit_inval");
        run_op(OP_HIT_INVALID, evicted);
        q = {evicted};
        run_fetches(q, wc);
        run_op(OP_HIT_INVALID, {20'hf_ffff, 7'h2a, 5'h0});
        // Only resident lines, so any burst here is a wrong invalidate
        q = {};
        for (int k = 0; k < 4; k++) begin
            if (m_valid[k][7'h2a]) begin
                q.push_back({m_tag[k][7'h2a], 7'h2a, 5'h04});
            end
        end
        run_fetches(q, wc);
        end_test();

        start_test("random_mix");
        for (int it = 0; it < 150; it++) begin
            r = next_rand();
            if (r[2:0] == 3'd0) begin
                if (r[3]) begin
                    run_op(OP_INDEX_INVALID,
                           {18'h0, r[5:4], 12'h0} | (pool_addr(next_rand()) & 32'hfe0));
                end else begin
                    run_op(OP_HIT_INVALID, pool_addr(next_rand()));
                end
            end else begin
                q = {};
                for (int k = 0; k < 4; k++) begin
                    q.push_back(pool_addr(next_rand()));
                end
                run_fetches(q, wc);
            end
        end
        end_test();

        $display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* hdl/icache_top.sv */
`timescale 1ns/10ps
`include "icache_macros.svh"

module icache_top (
    input  logic                      clk,
    input  logic                      rstn,
    // CPU fetch
    input  logic                      inst_req,
    input  logic [`ICACHE_ADDR_W-1:0] inst_addr,
    output logic                      inst_addr_ok,
    output logic                      inst_data_ok,
    output icache_pkg::word_t         inst_rdata,
    // Maintenance
    input  logic                      cache_req,
    input  icache_pkg::cache_op_e     cache_op,
    input  logic [`ICACHE_ADDR_W-1:0] cache_addr,
    output logic                      cache_op_ok,
    // Memory read burst
    output logic [`ICACHE_ADDR_W-1:0] araddr,
    output logic                      arvalid,
    input  logic                      arready,
    input  icache_pkg::word_t         rdata,
    input  logic                      rvalid,
    input  logic                      rlast,
    output logic                      rready
);
    import icache_pkg::*;

    index_t    rd_index;
    word_sel_t rd_word;
    tag_t      cmp_tag;
    way_mask_t hit_way;
    way_mask_t wr_way;
    index_t    wr_index;
    tag_t      wr_tag;
    logic      wr_valid;
    way_mask_t d_wr_way;
    word_sel_t d_wr_word;
    word_t     d_wr_data;
    way_mask_t victim_way;
    logic      sweep_en;
    index_t    sweep_index;
    logic      touch;
    index_t    touch_index;
    way_mask_t touch_way;

    // Port names match the nets one for one
    icache_ctrl u_ctrl (.*);

    icache_tag_array u_tag (.*);

    icache_data_array u_data (
        .clk      (clk),
        .rd_index (rd_index),
        .rd_word  (rd_word),
        .hit_way  (hit_way),
        .wr_way   (d_wr_way),
        .wr_index (wr_index),
        .wr_word  (d_wr_word),
        .wr_data  (d_wr_data),
        .rdata    (inst_rdata)
    );

    // Victim is looked up for the pending index
    icache_plru u_plru (
        .*,
        .lookup_index (touch_index)
    );

endmodule

/* hdl/icache_ctrl.sv */
`timescale 1ns/10ps
`include "icache_macros.svh"

module icache_ctrl (
    input  logic                      clk,
    input  logic                      rstn,
    // CPU fetch
    input  logic                      inst_req,
    input  logic [`ICACHE_ADDR_W-1:0] inst_addr,
    output logic                      inst_addr_ok,
    output logic                      inst_data_ok,
    // Maintenance
    input  logic                      cache_req,
    input  icache_pkg::cache_op_e     cache_op,
    input  logic [`ICACHE_ADDR_W-1:0] cache_addr,
    output logic                      cache_op_ok,
    // Memory read burst
    output logic [`ICACHE_ADDR_W-1:0] araddr,
    output logic                      arvalid,
    input  logic                      arready,
    input  icache_pkg::word_t         rdata,
    input  logic                      rvalid,
    input  logic                      rlast,
    output logic                      rready,
    // Array lookup
    output icache_pkg::index_t        rd_index,
    output icache_pkg::word_sel_t     rd_word,
    output icache_pkg::tag_t          cmp_tag,
    input  icache_pkg::way_mask_t     hit_way,
    // Tag write
    output icache_pkg::way_mask_t     wr_way,
    output icache_pkg::index_t        wr_index,
    output icache_pkg::tag_t          wr_tag,
    output logic                      wr_valid,
    // Data write
    output icache_pkg::way_mask_t     d_wr_way,
    output icache_pkg::word_sel_t     d_wr_word,
    output icache_pkg::word_t         d_wr_data,
    // PLRU
    input  icache_pkg::way_mask_t     victim_way,
    output logic                      sweep_en,
    output icache_pkg::index_t        sweep_index,
    output logic                      touch,
    output icache_pkg::index_t        touch_index,
    output icache_pkg::way_mask_t     touch_way
);
    import icache_pkg::*;

    localparam int WORD_LSB = `ICACHE_OFFSET_W - `ICACHE_WORD_SEL_W;
    localparam int OP_WAY_W = $clog2(`ICACHE_WAYS);

    function automatic tag_t addr_tag(input logic [`ICACHE_ADDR_W-1:0] a);
        return a[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    endfunction

    function automatic index_t addr_index(input logic [`ICACHE_ADDR_W-1:0] a);
        return a[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    endfunction

    function automatic word_sel_t addr_word(input logic [`ICACHE_ADDR_W-1:0] a);
        return a[WORD_LSB +: `ICACHE_WORD_SEL_W];
    endfunction

    ctrl_state_e               state;
    index_t                    sweep_cnt;
    word_sel_t                 fill_word;
    logic                      pend_valid;
    logic [`ICACHE_ADDR_W-1:0] pend_addr;
    logic [`ICACHE_ADDR_W-1:0] look_addr;
    logic                      hit;
    logic                      miss_now;
    way_mask_t                 op_way;

    ////////////////////////////////////////////////////////////
    // CPU and memory strobes
    ////////////////////////////////////////////////////////////
    assign hit      = |hit_way;
    assign miss_now = (state == RUN) && pend_valid && !hit;

    // A hit frees the slot in the same cycle for the next address
    assign inst_data_ok = (state == RUN) && pend_valid && hit;
    assign inst_addr_ok = (state == RUN) && inst_req && !cache_req
                          && (!pend_valid || hit);
    assign cache_op_ok  = (state == OP_APPLY);

    assign araddr  = {pend_addr[`ICACHE_ADDR_W-1:2], 2'b00};
    assign arvalid = (state == MISS);
    assign rready  = (state == REFILL);

    ////////////////////////////////////////////////////////////
    // Array lookup and writes
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (state)
            OP_READ: look_addr = cache_addr;
            REPLAY:  look_addr = pend_addr;
            default: look_addr = inst_addr;
        endcase
    end

    assign rd_index = addr_index(look_addr);
    assign rd_word  = addr_word(look_addr);
    assign cmp_tag  = addr_tag(look_addr);

    // Index-invalidate names the way, hit-invalidate uses the match
    assign op_way = (cache_op == OP_INDEX_INVALID)
                    ? way_mask_t'(1) << cache_addr[`ICACHE_OP_WAY_LSB +: OP_WAY_W]
                    : hit_way;

    always_comb begin
        wr_way   = '0;
        wr_index = addr_index(pend_addr);
        if (state == RESET_SWEEP) begin
            wr_way   = '1;
            wr_index = sweep_cnt;
        end else if (state == OP_APPLY) begin
            wr_way   = op_way;
            wr_index = addr_index(cache_addr);
        end else if (miss_now) begin
            wr_way = victim_way;
        end
    end

    // Victim tag goes in as valid when the miss is taken
    assign wr_tag   = addr_tag(pend_addr);
    assign wr_valid = miss_now;

    // PLRU is untouched during a fill, so the victim stays put
    assign d_wr_way  = (state == REFILL && rvalid) ? victim_way : '0;
    assign d_wr_word = fill_word;
    assign d_wr_data = rdata;

    assign sweep_en    = (state == RESET_SWEEP);
    assign sweep_index = sweep_cnt;
    assign touch       = inst_data_ok;
    assign touch_index = addr_index(pend_addr);
    assign touch_way   = hit_way;

    ////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state      <= RESET_SWEEP;
            sweep_cnt  <= '0;
            pend_valid <= 1'b0;
        end else begin
            if (inst_addr_ok) begin
                pend_valid <= 1'b1;
            end else if (inst_data_ok) begin
                pend_valid <= 1'b0;
            end
            case (state)
                RESET_SWEEP: begin
                    sweep_cnt <= sweep_cnt + 1'b1;
                    if (sweep_cnt == index_t'(`ICACHE_SETS - 1)) begin
                        state <= RUN;
                    end
                end
                RUN: begin
                    // Outstanding lookup goes before maintenance
                    if (miss_now) begin
                        state <= MISS;
                    end else if (cache_req && !pend_valid) begin
                        state <= OP_READ;
                    end
                end
                MISS: begin
                    if (arready) begin
                        state <= REFILL;
                    end
                end
                REFILL: begin
                    if (rvalid && rlast) begin
                        state <= REPLAY;
                    end
                end
                REPLAY:   state <= RUN;
                OP_READ:  state <= OP_APPLY;
                OP_APPLY: state <= RUN;
                default:  state <= RUN;
            endcase
        end
    end

    // Pending address and wrap counter of the burst
    always_ff @(posedge clk) begin
        if (inst_addr_ok) begin
            pend_addr <= inst_addr;
        end
        if (miss_now) begin
            fill_word <= addr_word(pend_addr);
        end else if (rready && rvalid) begin
            fill_word <= fill_word + 1'b1;
        end
    end

    a_burst_phases: assert property (@(posedge clk) disable iff (!rstn)
        !(arvalid && rready))
        else $error("ctrl: address and data phase overlap");

    // Data comes one cycle after its accept or one cycle after a replay
    a_data_source: assert property (@(posedge clk) disable iff (!rstn)
        inst_data_ok |-> $past(inst_addr_ok) || $past(state == REPLAY))
        else $error("ctrl: data return without a pending request");

endmodule

/* hdl/icache_plru.sv */
`timescale 1ns/10ps
`include "icache_macros.svh"

module icache_plru (
    input  logic                  clk,
    input  logic                  sweep_en,
    input  icache_pkg::index_t    sweep_index,
    input  icache_pkg::index_t    lookup_index,
    output icache_pkg::way_mask_t victim_way,
    input  logic                  touch,
    input  icache_pkg::index_t    touch_index,
    input  icache_pkg::way_mask_t touch_way
);
    import icache_pkg::*;

    localparam int B2 = 2;
    localparam int B1 = 1;
    localparam int B0 = 0;

    plru_t plru_mem [`ICACHE_SETS];
    plru_t look_bits;
    plru_t touch_bits;

    assign look_bits = plru_mem[lookup_index];

    // B2 picks the half, B1 or B0 the way within it
    always_comb begin
        if (!look_bits[B2]) begin
            victim_way = look_bits[B1] ? 4'b0010 : 4'b0001;
        end else begin
            victim_way = look_bits[B0] ? 4'b1000 : 4'b0100;
        end
    end

    // Point the tree away from the touched way
    always_comb begin
        touch_bits = plru_mem[touch_index];
        case (touch_way)
            4'b0001: {touch_bits[B2], touch_bits[B1]} = 2'b11;
            4'b0010: {touch_bits[B2], touch_bits[B1]} = 2'b10;
            4'b0100: {touch_bits[B2], touch_bits[B0]} = 2'b01;
            4'b1000: {touch_bits[B2], touch_bits[B0]} = 2'b00;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (sweep_en) begin
            plru_mem[sweep_index] <= '0;
        end else if (touch) begin
            plru_mem[touch_index] <= touch_bits;
        end
    end

    // Each returned word comes from exactly one hitting way
    a_one_way: assert property (@(posedge clk)
        $onehot(victim_way) && (!touch || $onehot(touch_way)))
        else $error("plru: victim or touched way not one-hot");

endmodule

/* hdl/icache_data_array.sv */
`timescale 1ns/10ps
`include "icache_macros.svh"

module icache_data_array (
    input  logic                  clk,
    input  icache_pkg::index_t    rd_index,
    input  icache_pkg::word_sel_t rd_word,
    input  icache_pkg::way_mask_t hit_way,
    input  icache_pkg::way_mask_t wr_way,
    input  icache_pkg::index_t    wr_index,
    input  icache_pkg::word_sel_t wr_word,
    input  icache_pkg::word_t     wr_data,
    output icache_pkg::word_t     rdata
);
    import icache_pkg::*;

    localparam int DEPTH = `ICACHE_SETS * `ICACHE_WORDS;

    // Registered word of every way
    word_t way_word [`ICACHE_WAYS];

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        word_t mem [DEPTH];
        word_t rd_q;

        // Word address is index then word select
        always_ff @(posedge clk) begin
            if (wr_way[w]) begin
                mem[{wr_index, wr_word}] <= wr_data;
            end
            rd_q <= mem[{rd_index, rd_word}];
        end

        assign way_word[w] = rd_q;
    end

    // hit_way is one-hot or zero, so an OR of masked words selects
    always_comb begin
        rdata = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (hit_way[w]) begin
                rdata = rdata | way_word[w];
            end
        end
    end

endmodule

/* hdl/icache_tag_array.sv */
`timescale 1ns/10ps
`include "icache_macros.svh"

module icache_tag_array (
    input  logic                  clk,
    input  icache_pkg::index_t    rd_index,
    input  icache_pkg::tag_t      cmp_tag,
    input  icache_pkg::way_mask_t wr_way,
    input  icache_pkg::index_t    wr_index,
    input  icache_pkg::tag_t      wr_tag,
    input  logic                  wr_valid,
    output icache_pkg::way_mask_t hit_way
);
    import icache_pkg::*;

    // Tag to compare, aligned with the registered read
    tag_t cmp_tag_q;

    always_ff @(posedge clk) begin
        cmp_tag_q <= cmp_tag;
    end

    ////////////////////////////////////////////////////////////
    // One tag and valid store per way
    ////////////////////////////////////////////////////////////
    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        tag_t tag_mem   [`ICACHE_SETS];
        logic valid_mem [`ICACHE_SETS];
        tag_t rd_tag;
        logic rd_valid;

        always_ff @(posedge clk) begin
            if (wr_way[w]) begin
                tag_mem[wr_index]   <= wr_tag;
                valid_mem[wr_index] <= wr_valid;
            end
            rd_tag   <= tag_mem[rd_index];
            rd_valid <= valid_mem[rd_index];
        end

        assign hit_way[w] = rd_valid && (rd_tag == cmp_tag_q);
    end

    // A line is only ever filled into one way, so two ways never match
    a_hit_onehot0: assert property (@(posedge clk) $onehot0(hit_way))
        else $error("tag array: more than one way hit");

endmodule

/* hdl/icache_pkg.sv */
`include "icache_macros.svh"

package icache_pkg;

    // Address fields
    typedef logic [`ICACHE_TAG_W-1:0]      tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0]    index_t;
    typedef logic [`ICACHE_WORD_SEL_W-1:0] word_sel_t;
    typedef logic [31:0]                   word_t;

    // One-hot way select
    typedef logic [`ICACHE_WAYS-1:0]       way_mask_t;

    // B2, B1, B0 of one set
    typedef logic [`ICACHE_PLRU_W-1:0]     plru_t;

    typedef enum logic [2:0] {
        RESET_SWEEP,    // Clears one set per cycle
        RUN,            // Lookup and hit return
        MISS,           // Burst address phase
        REFILL,         // Burst data phase
        REPLAY,         // Re-read of the filled line
        OP_READ,        // Tag read for maintenance
        OP_APPLY        // Valid clear and completion
    } ctrl_state_e;

    typedef enum logic {
        OP_INDEX_INVALID,
        OP_HIT_INVALID
    } cache_op_e;

endpackage

/* hdl/icache_macros.svh */
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// Address split, tag 31..12, index 11..5, word 4..2
`define ICACHE_ADDR_W      32
`define ICACHE_TAG_W       20
`define ICACHE_INDEX_W     7
`define ICACHE_OFFSET_W    5
`define ICACHE_WORD_SEL_W  3

// Geometry
`define ICACHE_WAYS        4
`define ICACHE_SETS        128
`define ICACHE_WORDS       8

// Tree PLRU bits per set
`define ICACHE_PLRU_W      3

// Index-invalidate takes its way from address bits 13..12
`define ICACHE_OP_WAY_LSB  12

`endif
